// ==== run.sh ====
#!/usr/bin/env bash
# build the core and its testbench with Verilator, run, look for the pass line
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f rv_core.f --top-module rv_core_tb -o rv_core_sim; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/rv_core_sim)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

// ==== rv_core.f ====
source/rv_core_pkg.sv
source/ifu.sv
source/idu.sv
source/regfile.sv
source/exu.sv
source/commit.sv
source/rv_core.sv
tests/rv_core_tb.sv

// ==== source/commit.sv ====
`timescale 1ns/1ps

module commit import rv_core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            is_ebreak,
    input  logic            reg_write_en,
    input  logic [4:0]      rd_addr,
    input  logic [31:0]     result,
    input  logic [31:0]     next_pc,
    output logic            rf_we,
    output logic [4:0]      rf_waddr,
    output logic [31:0]     rf_wdata,
    output logic            pc_load,
    output logic [31:0]     pc_next,
    output logic            halted,
    output logic [31:0]     instret
);

    logic [xlen-1:0] instret_q;
    logic            halted_q;

    // nothing retires after ebreak
    assign rf_we    = reg_write_en && !halted_q;
    assign rf_waddr = rd_addr;
    assign rf_wdata = result;
    assign pc_load  = !halted_q;
    assign pc_next  = next_pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted_q  <= 1'b0;
            instret_q <= '0;
        end else if (!halted_q) begin
            instret_q <= instret_q + 32'd1; // ebreak counts too
            if (is_ebreak) begin
                halted_q <= 1'b1;
            end
        end
    end

    assign halted  = halted_q;
    assign instret = instret_q;

endmodule

// ==== source/exu.sv ====
`timescale 1ns/1ps

module exu import rv_core_pkg::*; (
    input  logic [31:0]     rs1_data,
    input  logic [31:0]     rs2_data,
    input  logic [31:0]     imm,
    input  logic            reg_write_en,
    input  logic [4:0]      rd_addr,
    input  logic [31:0]     pc,
    input  logic [6:0]      opcode,
    input  logic [2:0]      funct3,
    input  logic [31:0]     mem_data,
    output logic [31:0]     result,
    output logic [4:0]      rd_addr_out,
    output logic            reg_write_en_out,
    output logic [31:0]     next_pc,
    output logic [31:0]     mem_addr
);

    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_sum;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] jalr_target;
    logic [xlen-1:0] branch_target;
    logic            branch_taken;

    always_comb begin
        case (opcode)
            op_auipc, op_jal: alu_a = pc;
            op_lui:           alu_a = '0;
            default:          alu_a = rs1_data;
        endcase
    end

    assign alu_sum  = alu_a + imm; // also the jal target
    assign mem_addr = alu_sum;

    assign pc_plus4      = pc + 32'd4;
    assign jalr_target   = alu_sum & ~32'h1;
    assign branch_target = pc + imm;
    assign branch_taken  = (funct3 == f3_beq) && (rs1_data == rs2_data);

    always_comb begin
        case (opcode)
            op_jal, op_jalr: result = pc_plus4; // link value
            op_load:         result = mem_data;
            default:         result = alu_sum;
        endcase
    end

    always_comb begin
        case (opcode)
            op_jal: begin
                next_pc = alu_sum;
            end
            op_jalr: begin
                next_pc = (funct3 == f3_jalr) ? jalr_target : pc_plus4;
            end
            op_branch: begin
                next_pc = branch_taken ? branch_target : pc_plus4;
            end
            default: begin
                next_pc = pc_plus4;
            end
        endcase
    end

    assign rd_addr_out      = rd_addr;
    assign reg_write_en_out = reg_write_en;

endmodule

// ==== source/idu.sv ====
`timescale 1ns/1ps

module idu import rv_core_pkg::*; (
    input  inst_t           inst,
    output logic [4:0]      rs1_addr,
    output logic [4:0]      rs2_addr,
    output logic [4:0]      rd_addr,
    output logic [31:0]     imm,
    output logic [6:0]      opcode,
    output logic [2:0]      funct3,
    output logic            reg_write_en,
    output logic            is_ebreak
);

    logic writes_rd;

    // fields sit at the same bits in every layout
    assign opcode   = inst.i_view.opcode;
    assign funct3   = inst.i_view.funct3;
    assign rd_addr  = inst.i_view.rd;
    assign rs1_addr = inst.i_view.rs1;
    assign rs2_addr = inst.b_view.rs2;

    assign is_ebreak = (inst == inst_ebreak);

    always_comb begin
        case (inst.i_view.opcode)
            op_lui, op_auipc: begin
                imm = {inst.u_view.imm_31_12, 12'b0};
            end
            op_jal: begin
                imm = {{11{inst.j_view.imm_20}},
                       inst.j_view.imm_20,
                       inst.j_view.imm_19_12,
                       inst.j_view.imm_11,
                       inst.j_view.imm_10_1,
                       1'b0};
            end
            op_branch: begin
                imm = {{19{inst.b_view.imm_12}},
                       inst.b_view.imm_12,
                       inst.b_view.imm_11,
                       inst.b_view.imm_10_5,
                       inst.b_view.imm_4_1,
                       1'b0};
            end
            op_jalr, op_load, op_imm: begin
                imm = {{20{inst.i_view.imm[11]}}, inst.i_view.imm};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

    always_comb begin
        case (inst.i_view.opcode)
            op_lui, op_auipc, op_jal: writes_rd = 1'b1;
            op_jalr:                  writes_rd = (inst.i_view.funct3 == f3_jalr);
            op_imm:                   writes_rd = (inst.i_view.funct3 == f3_addi);
            op_load:                  writes_rd = (inst.i_view.funct3 == f3_lw);
            default:                  writes_rd = 1'b0;
        endcase
    end

    // x0 never gets a write strobe
    assign reg_write_en = writes_rd && (inst.i_view.rd != 5'd0);

endmodule

// ==== source/ifu.sv ====
`timescale 1ns/1ps

module ifu import rv_core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            pc_load,
    input  logic [31:0]     pc_next,
    input  logic [31:0]     inst_raw,
    output logic [31:0]     pc,
    output inst_t           inst
);

    logic [xlen-1:0] pc_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= reset_pc;
        end else if (pc_load) begin
            pc_q <= pc_next; // held once halted
        end
    end

    assign pc = pc_q;

    // memory answers in the same cycle
    assign inst = inst_raw;

endmodule

// ==== source/regfile.sv ====
`timescale 1ns/1ps

module regfile import rv_core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [4:0]      rs1_addr,
    input  logic [4:0]      rs2_addr,
    output logic [31:0]     rs1_data,
    output logic [31:0]     rs2_data,
    input  logic            we,
    input  logic [4:0]      waddr,
    input  logic [31:0]     wdata
);

    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // async read, x0 hardwired
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// ==== source/rv_core.sv ====
`timescale 1ns/1ps

module rv_core import rv_core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [31:0]     inst,
    output logic [31:0]     pc,
    output logic [31:0]     mem_addr,
    input  logic [31:0]     mem_rdata,
    output logic            wb_en,
    output logic [4:0]      wb_addr,
    output logic [31:0]     wb_data,
    output logic            halted,
    output logic [31:0]     instret
);

    inst_t           inst_dec;
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [4:0]      rd_addr;
    logic [xlen-1:0] imm;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            reg_write_en;
    logic            is_ebreak;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] result;
    logic [4:0]      rd_addr_ex;
    logic            reg_write_en_ex;
    logic [xlen-1:0] next_pc;
    logic            pc_load;
    logic [xlen-1:0] pc_next;

    ifu u_ifu (
        .clk      (clk),
        .rst_n    (rst_n),
        .pc_load  (pc_load),
        .pc_next  (pc_next),
        .inst_raw (inst),
        .pc       (pc),
        .inst     (inst_dec)
    );

    idu u_idu (
        .inst         (inst_dec),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rd_addr      (rd_addr),
        .imm          (imm),
        .opcode       (opcode),
        .funct3       (funct3),
        .reg_write_en (reg_write_en),
        .is_ebreak    (is_ebreak)
    );

    regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (wb_en),
        .waddr    (wb_addr),
        .wdata    (wb_data)
    );

    exu u_exu (
        .rs1_data         (rs1_data),
        .rs2_data         (rs2_data),
        .imm              (imm),
        .reg_write_en     (reg_write_en),
        .rd_addr          (rd_addr),
        .pc               (pc),
        .opcode           (opcode),
        .funct3           (funct3),
        .mem_data         (mem_rdata),
        .result           (result),
        .rd_addr_out      (rd_addr_ex),
        .reg_write_en_out (reg_write_en_ex),
        .next_pc          (next_pc),
        .mem_addr         (mem_addr)
    );

    // write port doubles as the observation output
    commit u_commit (
        .clk          (clk),
        .rst_n        (rst_n),
        .is_ebreak    (is_ebreak),
        .reg_write_en (reg_write_en_ex),
        .rd_addr      (rd_addr_ex),
        .result       (result),
        .next_pc      (next_pc),
        .rf_we        (wb_en),
        .rf_waddr     (wb_addr),
        .rf_wdata     (wb_data),
        .pc_load      (pc_load),
        .pc_next      (pc_next),
        .halted       (halted),
        .instret      (instret)
    );

endmodule

// ==== source/rv_core_pkg.sv ====
package rv_core_pkg;

    localparam int xlen = 32;

    // base opcodes, inst[6:0]
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [2:0] f3_addi = 3'b000;
    localparam logic [2:0] f3_lw   = 3'b010;
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_jalr = 3'b000;

    localparam logic [31:0] inst_ebreak = 32'h0010_0073;

    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

    // one fetched word, seen through the four immediate layouts
    typedef union packed {
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_view;
        struct packed {
            logic        imm_12;
            logic [5:0]  imm_10_5;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [3:0]  imm_4_1;
            logic        imm_11;
            logic [6:0]  opcode;
        } b_view;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_view;
        struct packed {
            logic        imm_20;
            logic [9:0]  imm_10_1;
            logic        imm_11;
            logic [7:0]  imm_19_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } j_view;
    } inst_t;

endpackage

// ==== tests/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb import rv_core_pkg::*; ();

    localparam int n_rows       = 20;
    localparam int reset_cycles = 16;
    localparam int timeout_ns   = (n_rows + reset_cycles + 8) * 40;

    typedef struct packed {
        inst_t       inst;
        logic [31:0] load;
        logic [31:0] exp_pc;
        logic        exp_wb_en;
        logic [4:0]  exp_wb_addr;
        logic [31:0] exp_wb_data;
        logic        chk_mem;
        logic [31:0] exp_mem_addr;
        logic        exp_halted;
        logic [31:0] exp_instret;
    } row_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] inst;
    logic [31:0] pc;
    logic [31:0] mem_addr;
    logic [31:0] mem_rdata;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        halted;
    logic [31:0] instret;

    row_t        rows [n_rows];
    int          n_fill;
    int          cur_row;
    logic [15:0] lfsr;
    int          word_errs;
    int          addr_errs;
    int          bit_errs;
    int          n_checks;

    rv_core u_rv_core (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst      (inst),
        .pc        (pc),
        .mem_addr  (mem_addr),
        .mem_rdata (mem_rdata),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .halted    (halted),
        .instret   (instret)
    );

    always #20 clk = ~clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
    endfunction

    task automatic add_row(input logic [31:0] word);
        rows[n_fill] = '0;
        rows[n_fill].inst = word;
        rows[n_fill].load = rand_bits(32); // ignored unless lw
        n_fill++;
    endtask

    task automatic build_program();
        logic [31:0] r;
        n_fill = 0;
        lfsr = 16'd11119;
        add_row(enc_u(20'h12345, 5'd1, op_lui));
        add_row(enc_u(20'h00010, 5'd2, op_auipc));
        r = rand_bits(12);
        add_row(enc_i(r[11:0], 5'd1, f3_addi, 5'd3, op_imm));
        add_row(enc_i(12'd5, 5'd1, f3_addi, 5'd0, op_imm));    // write to x0 dropped
        add_row(enc_i(12'd0, 5'd0, f3_addi, 5'd4, op_imm));    // x0 reads zero
        add_row(enc_i(12'd0, 5'd3, f3_addi, 5'd5, op_imm));    // reveals x3
        add_row(enc_i(12'hfff, 5'd0, f3_addi, 5'd6, op_imm));
        add_row(enc_j(21'd16, 5'd7));
        r = rand_bits(20);
        add_row(enc_u(r[19:0], 5'd8, op_lui));
        add_row(enc_u(20'h0, 5'd9, op_auipc));
        add_row(enc_i(12'd21, 5'd9, f3_jalr, 5'd11, op_jalr)); // odd target
        add_row(enc_b(13'd24, 5'd0, 5'd4, f3_beq));           // taken
        add_row(enc_b(13'h1ff8, 5'd2, 5'd1, f3_beq));         // not taken
        r = rand_bits(12);
        add_row(enc_i(r[11:0], 5'd1, f3_lw, 5'd12, op_load));
        add_row(enc_i(12'hffc, 5'd2, f3_lw, 5'd13, op_load));
        add_row(enc_i(12'd0, 5'd12, f3_addi, 5'd14, op_imm));  // reveals loaded x12
        add_row(inst_ebreak);
        add_row(enc_i(12'd7, 5'd0, f3_addi, 5'd15, op_imm));   // core is halted here on
        add_row(enc_u(20'habcde, 5'd16, op_lui));
        add_row(enc_j(21'h1fffe0, 5'd1));
    endtask

    // shadow register file and pc, stepped through the table
    task automatic predict_rows();
        logic [31:0] regs [32];
        logic [31:0] w;
        logic [31:0] pc_m;
        logic [31:0] cnt;
        logic        halt_m;
        logic [6:0]  op;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic        we;
        logic [31:0] wd;
        logic [31:0] npc;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc_m = reset_pc;
        cnt = '0;
        halt_m = 1'b0;
        for (int k = 0; k < n_rows; k++) begin
            w = rows[k].inst;
            op = w[6:0];
            rd = w[11:7];
            f3 = w[14:12];
            a = regs[w[19:15]];
            b = regs[w[24:20]];
            imm_i = {{20{w[31]}}, w[31:20]};
            imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            imm_u = {w[31:12], 12'h000};
            imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            we = 1'b0;
            wd = '0;
            npc = pc_m + 32'd4;
            case (op)
                op_lui: begin
                    we = 1'b1;
                    wd = imm_u;
                end
                op_auipc: begin
                    we = 1'b1;
                    wd = pc_m + imm_u;
                end
                op_imm: begin
                    we = (f3 == f3_addi);
                    wd = a + imm_i;
                end
                op_jal: begin
                    we = 1'b1;
                    wd = pc_m + 32'd4;
                    npc = pc_m + imm_j;
                end
                op_jalr: begin
                    we = 1'b1;
                    wd = pc_m + 32'd4;
                    npc = (a + imm_i) & 32'hffff_fffe;
                end
                op_load: begin
                    we = (f3 == f3_lw);
                    wd = rows[k].load;
                    rows[k].chk_mem = 1'b1;
                    rows[k].exp_mem_addr = a + imm_i;
                end
                op_branch: begin
                    if (f3 == f3_beq && a == b) begin
                        npc = pc_m + imm_b;
                    end
                end
                default: begin
                end
            endcase
            we = we && (rd != 5'd0) && !halt_m;
            rows[k].exp_pc = pc_m;
            rows[k].exp_wb_en = we;
            rows[k].exp_wb_addr = rd;
            rows[k].exp_wb_data = wd;
            rows[k].exp_halted = halt_m;
            rows[k].exp_instret = cnt;
            if (!halt_m) begin
                if (we) begin
                    regs[rd] = wd;
                end
                pc_m = npc;
                cnt = cnt + 32'd1;
                halt_m = (w == inst_ebreak);
            end
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            word_errs++;
            $display("ERR %s row %0d: got 0x%h, expected 0x%h", name, cur_row, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [4:0] got,
                              input logic [4:0] exp);
        n_checks++;
        if (got !== exp) begin
            addr_errs++;
            $display("ERR %s row %0d: got 0x%h, expected 0x%h", name, cur_row, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            bit_errs++;
            $display("ERR %s row %0d: got 0x%h, expected 0x%h", name, cur_row, got, exp);
        end
    endtask

    task automatic check_row(input int k);
        check_word("pc", pc, rows[k].exp_pc);
        check_bit("wb_en", wb_en, rows[k].exp_wb_en);
        if (rows[k].exp_wb_en) begin
            check_addr("wb_addr", wb_addr, rows[k].exp_wb_addr);
            check_word("wb_data", wb_data, rows[k].exp_wb_data);
        end
        if (rows[k].chk_mem) begin
            check_word("mem_addr", mem_addr, rows[k].exp_mem_addr);
        end
        check_bit("halted", halted, rows[k].exp_halted);
        check_word("instret", instret, rows[k].exp_instret);
    endtask

    initial begin
        #(timeout_ns);
        $display("timeout: the stimulus table did not finish in the expected time");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        inst = '0;
        mem_rdata = '0;
        word_errs = 0;
        addr_errs = 0;
        bit_errs = 0;
        n_checks = 0;
        cur_row = -1; // reset phase
        build_program();
        predict_rows();
        repeat (reset_cycles) @(posedge clk);
        #2;
        check_word("pc", pc, reset_pc);
        check_bit("wb_en", wb_en, 1'b0);
        check_bit("halted", halted, 1'b0);
        check_word("instret", instret, 32'd0);
        rst_n = 1'b1;
        for (int k = 0; k < n_rows; k++) begin
            cur_row = k;
            inst = rows[k].inst;
            mem_rdata = rows[k].load;
            #18; // sample at the falling edge
            check_row(k);
            @(posedge clk);
            #2;
        end
        $display("checks %0d, errors %0d (word %0d, addr %0d, bit %0d)", n_checks,
                 word_errs + addr_errs + bit_errs, word_errs, addr_errs, bit_errs);
        if (word_errs + addr_errs + bit_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
